/* common/clic_pkg.sv */
// clic types, csr address map, config csr field positions, csr update function
`default_nettype none

package clic_pkg;

  // basic csr types
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] word;
  // zimm operand of the immediate forms
  typedef logic [4:0] r;
  typedef logic [7:0] level_t;

  // funct3 encoding of the zicsr instructions
  typedef enum logic [2:0] {
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } csr_t;

  // named machine mode csrs
  localparam csr_addr_t MStatusAddr    = 12'h300;
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t StackDepthAddr = 12'h350;
  // first per-vector config csr, one per vector upward
  localparam csr_addr_t IntCfgBase     = 12'hB00;

  // mie inside mstatus
  localparam int MieBit      = 3;
  // config csr layout
  localparam int CfgPendBit  = 0;
  localparam int CfgEnBit    = 1;
  localparam int CfgLevelLsb = 8;

  // next value of a csr word for one access
  function automatic word csr_update(input csr_t op, input word old, input r zimm,
                                     input word data);
    word operand;
    // immediate forms zero extend zimm
    case (op)
      CSRRWI, CSRRSI, CSRRCI: operand = {{($bits(word) - $bits(r)){1'b0}}, zimm};
      default:                operand = data;
    endcase
    case (op)
      CSRRW, CSRRWI: csr_update = operand;
      CSRRS, CSRRSI: csr_update = old | operand;
      CSRRC, CSRRCI: csr_update = old & ~operand;
      // undefined funct3 leaves the word alone
      default:       csr_update = old;
    endcase
  endfunction

endpackage

`default_nettype wire

/* common/csr_bus_if.sv */
// csr access interface and clic configuration interface, with their modports
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if
  import clic_pkg::*;
();
  // one access per cycle with enable high, no handshake
  logic      enable;
  csr_addr_t addr;
  csr_t      op;
  r          rs1_zimm;
  word       rs1_data;
  // old value, combinational from addr
  word       rdata;

  modport requester (output enable, addr, op, rs1_zimm, rs1_data, input rdata);
  modport responder (input enable, addr, op, rs1_zimm, rs1_data, output rdata);
endinterface

interface clic_cfg_if
  import clic_pkg::*;
#(
  parameter int VecSize = 8
) ();
  localparam int IdWidth = $clog2(VecSize);

  // state unpacked from the csr bank
  logic [VecSize-1:0] pending;
  logic [VecSize-1:0] enable_mask;
  level_t             level [VecSize];
  level_t             thresh;
  logic               mie;
  // accepted interrupt, clears its pending bit
  logic               take;
  logic [IdWidth-1:0] take_id;

  modport csr_side (output pending, enable_mask, level, thresh, mie, input take, take_id);
  modport arb_side (input pending, enable_mask, level, thresh, mie, output take, take_id);
endinterface

`default_nettype wire

/* logic/csr_reg.sv */
// csr_reg module, one csr word with address decode, csrrw/rs/rc update and hw write port
`timescale 1ns/1ps
`default_nettype none

module csr_reg
  import clic_pkg::*;
#(
  parameter csr_addr_t Addr       = '0,
  parameter word       ResetValue = '0,
  parameter bit        Read       = 1'b1,
  parameter bit        Write      = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      en,
  input  csr_addr_t addr,
  input  r          rs1_zimm,
  input  word       rs1_data,
  input  csr_t      op,
  input  logic      hw_we,
  input  word       hw_data,
  output logic      match,
  output word       out
);

  word value;
  word sw_next;

  // address decode
  assign match = (addr == Addr);

  // write, set or clear result for this access
  // zero operand on set/clear keeps the word as is
  assign sw_next = csr_update(op, value, rs1_zimm, rs1_data);

  // hw port wins over the software access
  // read-only cells keep their reset value for software
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= ResetValue;
    end else if (hw_we) begin
      value <= hw_data;
    end else if (en && match && Write) begin
      value <= sw_next;
    end
  end

  // unreadable cells show zero
  assign out = Read ? value : '0;

endmodule

`default_nettype wire

/* clic/clic_csr_file.sv */
// clic_csr_file module, named csrs, per-vector config csrs, pending edge capture, read mux
`timescale 1ns/1ps
`default_nettype none

module clic_csr_file
  import clic_pkg::*;
#(
  parameter int VecSize = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  csr_bus_if.responder       bus,
  clic_cfg_if.csr_side       cfg,
  input  logic [VecSize-1:0] irq_in
);

  localparam int IdWidth  = $clog2(VecSize);
  localparam int NamedCnt = 3;

  typedef struct packed {
    csr_addr_t addr;
    word       reset_val;
    bit        read;
    bit        write;
  } csr_entry_t;

  // mstatus, mintthresh, stack_depth in this order
  localparam csr_entry_t CsrTable[NamedCnt] = '{
    '{MStatusAddr,    32'd0, 1'b1, 1'b1},
    '{MIntThreshAddr, 32'd0, 1'b1, 1'b1},
    '{StackDepthAddr, 32'd8, 1'b1, 1'b0}
  };

  logic named_match [NamedCnt];
  word  named_out   [NamedCnt];

  logic cfg_match   [VecSize];
  word  cfg_word    [VecSize];
  logic cfg_hw_we   [VecSize];
  word  cfg_hw_data [VecSize];

  // line sampled at this edge and at the edge before
  logic [VecSize-1:0] irq_s;
  logic [VecSize-1:0] irq_d;
  logic [VecSize-1:0] irq_rise;

  for (genvar k = 0; k < NamedCnt; k++) begin : gen_named
    csr_reg #(
      .Addr      (CsrTable[k].addr),
      .ResetValue(CsrTable[k].reset_val),
      .Read      (CsrTable[k].read),
      .Write     (CsrTable[k].write)
    ) u_csr (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (bus.enable),
      .addr    (bus.addr),
      .rs1_zimm(bus.rs1_zimm),
      .rs1_data(bus.rs1_data),
      .op      (bus.op),
      .hw_we   (1'b0),
      .hw_data ('0),
      .match   (named_match[k]),
      .out     (named_out[k])
    );
  end

  // one config csr per vector from IntCfgBase up
  for (genvar k = 0; k < VecSize; k++) begin : gen_cfg
    csr_reg #(
      .Addr      (csr_addr_t'(IntCfgBase + k)),
      .ResetValue('0),
      .Read      (1'b1),
      .Write     (1'b1)
    ) u_csr (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (bus.enable),
      .addr    (bus.addr),
      .rs1_zimm(bus.rs1_zimm),
      .rs1_data(bus.rs1_data),
      .op      (bus.op),
      .hw_we   (cfg_hw_we[k]),
      .hw_data (cfg_hw_data[k]),
      .match   (cfg_match[k]),
      .out     (cfg_word[k])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_s <= '0;
      irq_d <= '0;
    end else begin
      irq_s <= irq_in;
      irq_d <= irq_s;
    end
  end

  // high at edge n, low at edge n-1, pending set at edge n+1
  assign irq_rise = irq_s & ~irq_d;

  // pending merge order is sw write, then take clear, then hw set
  always_comb begin
    word base;
    logic clr;
    for (int k = 0; k < VecSize; k++) begin
      base = (bus.enable && cfg_match[k]) ?
             csr_update(bus.op, cfg_word[k], bus.rs1_zimm, bus.rs1_data) : cfg_word[k];
      clr = cfg.take && (cfg.take_id == IdWidth'(k));
      base[CfgPendBit] = (base[CfgPendBit] & ~clr) | irq_rise[k];
      cfg_hw_we[k] = clr || irq_rise[k];
      cfg_hw_data[k] = base;
    end
  end

  // unpack config fields for the arbiter
  always_comb begin
    for (int k = 0; k < VecSize; k++) begin
      cfg.pending[k]     = cfg_word[k][CfgPendBit];
      cfg.enable_mask[k] = cfg_word[k][CfgEnBit];
      cfg.level[k]       = cfg_word[k][CfgLevelLsb +: $bits(level_t)];
    end
  end

  assign cfg.mie    = named_out[0][MieBit];
  assign cfg.thresh = named_out[1][$bits(level_t)-1:0];

  // read mux, unmapped reads give zero
  always_comb begin
    bus.rdata = '0;
    for (int k = 0; k < NamedCnt; k++) begin
      if (named_match[k]) bus.rdata = named_out[k];
    end
    for (int k = 0; k < VecSize; k++) begin
      if (cfg_match[k]) bus.rdata = cfg_word[k];
    end
  end

endmodule

`default_nettype wire

/* clic/clic_arbiter.sv */
// clic_arbiter module, priority search over eligible vectors and registered valid/ready offer
`timescale 1ns/1ps
`default_nettype none

module clic_arbiter
  import clic_pkg::*;
#(
  parameter  int VecSize = 8,
  localparam int IdWidth = $clog2(VecSize)
) (
  input  logic               clk,
  input  logic               rst_n,
  clic_cfg_if.arb_side       cfg,
  output logic               irq_valid,
  input  logic               irq_ready,
  output logic [IdWidth-1:0] irq_id,
  output level_t             irq_level
);

  logic [VecSize-1:0] eligible;
  logic               found;
  logic [IdWidth-1:0] best_id;
  level_t             best_level;
  logic               transfer;

  // pending, enabled, above threshold, mie on
  // strict compare keeps the lower id on equal levels
  always_comb begin
    found      = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int k = 0; k < VecSize; k++) begin
      eligible[k] = cfg.mie && cfg.pending[k] && cfg.enable_mask[k] &&
                    (cfg.level[k] > cfg.thresh);
      if (eligible[k] && (!found || (cfg.level[k] > best_level))) begin
        found      = 1'b1;
        best_id    = IdWidth'(k);
        best_level = cfg.level[k];
      end
    end
  end

  assign transfer = irq_valid && irq_ready;

  // offer stays up until accepted
  // drops for one cycle after a transfer so the cleared pending is seen
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_valid <= 1'b0;
    end else if (transfer) begin
      irq_valid <= 1'b0;
    end else if (!irq_valid) begin
      irq_valid <= found;
    end
  end

  // payload only loads while no offer is outstanding
  always_ff @(posedge clk) begin
    if (!irq_valid) begin
      irq_id    <= best_id;
      irq_level <= best_level;
    end
  end

  // clear the accepted vector at the transfer edge
  assign cfg.take    = transfer;
  assign cfg.take_id = irq_id;

endmodule

`default_nettype wire

/* clic/clic_top.sv */
// clic_top module, csr bus and core interrupt ports around the csr file and arbiter
`timescale 1ns/1ps
`default_nettype none

module clic_top
  import clic_pkg::*;
#(
  parameter  int VecSize = 8,
  localparam int IdWidth = $clog2(VecSize)
) (
  input  logic               clk,
  input  logic               rst_n,
  // csr access from the core
  input  logic               csr_enable,
  input  csr_addr_t          csr_addr,
  input  r                   rs1_zimm,
  input  word                rs1_data,
  input  csr_t               op,
  output word                csr_rdata,
  // external interrupt lines
  input  logic [VecSize-1:0] irq_in,
  // interrupt offer to the core
  output logic               irq_valid,
  input  logic               irq_ready,
  output logic [IdWidth-1:0] irq_id,
  output level_t             irq_level
);

  csr_bus_if                          bus ();
  clic_cfg_if #(.VecSize(VecSize))    cfg ();

  // requester side of the csr bus
  assign bus.enable   = csr_enable;
  assign bus.addr     = csr_addr;
  assign bus.op       = op;
  assign bus.rs1_zimm = rs1_zimm;
  assign bus.rs1_data = rs1_data;
  assign csr_rdata    = bus.rdata;

  clic_csr_file #(
    .VecSize(VecSize)
  ) u_csr_file (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.responder),
    .cfg   (cfg.csr_side),
    .irq_in(irq_in)
  );

  clic_arbiter #(
    .VecSize(VecSize)
  ) u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg.arb_side),
    .irq_valid(irq_valid),
    .irq_ready(irq_ready),
    .irq_id   (irq_id),
    .irq_level(irq_level)
  );

endmodule

`default_nettype wire

/* sim/tb_clic.sv */
// tb_clic testbench with lfsr stimulus, clic reference model, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_clic
  import clic_pkg::*;
();

  localparam int VecSize = 8;
  localparam int IdWidth = $clog2(VecSize);
  // test lengths in cycles with 12 per read sweep
  localparam int SweepLen   = 12;
  localparam int CsrLen     = 300;
  localparam int PendLen    = 200;
  localparam int ArbLen     = 300;
  localparam int HsLen      = 300;
  localparam int CycleLimit = 8 + 3 * SweepLen + CsrLen + PendLen + ArbLen + HsLen + 200;

  logic               clk;
  logic               rst_n;
  logic               csr_enable;
  csr_addr_t          csr_addr;
  r                   rs1_zimm;
  word                rs1_data;
  csr_t               op;
  word                csr_rdata;
  logic [VecSize-1:0] irq_in;
  logic               irq_valid;
  logic               irq_ready;
  logic [IdWidth-1:0] irq_id;
  level_t             irq_level;

  // stimulus for the next edge
  logic               n_en;
  csr_addr_t          n_addr;
  csr_t               n_op;
  r                   n_zimm;
  word                n_data;
  logic [VecSize-1:0] n_irq;
  logic               n_ready;

  // reference model state
  word                m_mstatus;
  word                m_thresh;
  word                m_cfg [VecSize];
  logic [VecSize-1:0] m_irq_s;
  logic [VecSize-1:0] m_irq_d;
  logic               m_valid;
  logic [IdWidth-1:0] m_id;
  level_t             m_lvl;

  // offer seen at the previous negedge
  logic               prev_valid;
  logic               prev_ready;
  logic [IdWidth-1:0] prev_id;
  level_t             prev_lvl;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          cycle_count;
  int          errs_before;

  clic_top #(
    .VecSize(VecSize)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .op        (op),
    .csr_rdata (csr_rdata),
    .irq_in    (irq_in),
    .irq_valid (irq_valid),
    .irq_ready (irq_ready),
    .irq_id    (irq_id),
    .irq_level (irq_level)
  );

  always #10 clk = ~clk;

  // galois lfsr over x^32+x^22+x^2+x+1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // write, set or clear with register or zero extended immediate operand
  function automatic word apply_csr_op(input csr_t o, input word old, input r zimm,
                                       input word data);
    word opnd;
    opnd = (o == CSRRWI || o == CSRRSI || o == CSRRCI) ? word'(zimm) : data;
    case (o)
      CSRRW, CSRRWI: return opnd;
      CSRRS, CSRRSI: return old | opnd;
      default:       return old & ~opnd;
    endcase
  endfunction

  // 0..3 named csrs and one unmapped address, 4..11 config csrs
  function automatic csr_addr_t addr_of(input int sel);
    case (sel)
      0:       return MStatusAddr;
      1:       return MIntThreshAddr;
      2:       return StackDepthAddr;
      3:       return 12'h301;
      default: return csr_addr_t'(IntCfgBase + sel - 4);
    endcase
  endfunction

  function automatic csr_t random_op();
    case (rand_bits(3) % 6)
      0:       return CSRRW;
      1:       return CSRRS;
      2:       return CSRRC;
      3:       return CSRRWI;
      4:       return CSRRSI;
      default: return CSRRCI;
    endcase
  endfunction

  function automatic word model_read(input csr_addr_t a);
    if (a == MStatusAddr) return m_mstatus;
    if (a == MIntThreshAddr) return m_thresh;
    if (a == StackDepthAddr) return 32'd8;
    for (int k = 0; k < VecSize; k++) begin
      if (a == csr_addr_t'(IntCfgBase + k)) return m_cfg[k];
    end
    return '0;
  endfunction

  task automatic model_reset();
    m_mstatus = '0;
    m_thresh  = '0;
    for (int k = 0; k < VecSize; k++) m_cfg[k] = '0;
    m_irq_s = '0;
    m_irq_d = '0;
    m_valid = 1'b0;
    m_id    = '0;
    m_lvl   = '0;
  endtask

  // one clock edge of the model, from the inputs the dut samples now
  task automatic model_edge();
    logic               transfer;
    logic               found;
    logic [IdWidth-1:0] bid;
    level_t             blvl;
    level_t             lv;
    logic [VecSize-1:0] rise;
    transfer = m_valid && irq_ready;
    found = 1'b0;
    bid   = '0;
    blvl  = '0;
    // winner over the state before this edge
    for (int k = 0; k < VecSize; k++) begin
      lv = m_cfg[k][CfgLevelLsb +: 8];
      if (m_mstatus[MieBit] && m_cfg[k][CfgPendBit] && m_cfg[k][CfgEnBit] &&
          lv > m_thresh[7:0] && (!found || lv > blvl)) begin
        found = 1'b1;
        bid   = IdWidth'(k);
        blvl  = lv;
      end
    end
    // sw write first while stack_depth ignores writes
    if (csr_enable) begin
      if (csr_addr == MStatusAddr) m_mstatus = apply_csr_op(op, m_mstatus, rs1_zimm, rs1_data);
      if (csr_addr == MIntThreshAddr) m_thresh = apply_csr_op(op, m_thresh, rs1_zimm, rs1_data);
      for (int k = 0; k < VecSize; k++) begin
        if (csr_addr == csr_addr_t'(IntCfgBase + k)) begin
          m_cfg[k] = apply_csr_op(op, m_cfg[k], rs1_zimm, rs1_data);
        end
      end
    end
    // then take clear, then hw edge set
    rise = m_irq_s & ~m_irq_d;
    for (int k = 0; k < VecSize; k++) begin
      if (transfer && m_id == IdWidth'(k)) m_cfg[k][CfgPendBit] = 1'b0;
      if (rise[k]) m_cfg[k][CfgPendBit] = 1'b1;
    end
    m_irq_d = m_irq_s;
    m_irq_s = irq_in;
    if (!m_valid) begin
      m_id  = bid;
      m_lvl = blvl;
    end
    if (transfer) m_valid = 1'b0;
    else if (!m_valid) m_valid = found;
  endtask

  task automatic check_word(input string name, input word exp, input word act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %08h got %08h at cycle %0d", name, exp, act, cycle_count);
    end
  endtask

  task automatic check_id(input string name, input logic [IdWidth-1:0] exp,
                          input logic [IdWidth-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %0h got %0h at cycle %0d", name, exp, act, cycle_count);
    end
  endtask

  task automatic check_level(input string name, input level_t exp, input level_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %02h got %02h at cycle %0d", name, exp, act, cycle_count);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %0h got %0h at cycle %0d", name, exp, act, cycle_count);
    end
  endtask

  // model and dut step on the rising edge and outputs are checked at the falling edge
  task automatic cycle();
    @(posedge clk);
    model_edge();
    csr_enable <= n_en;
    csr_addr   <= n_addr;
    op         <= n_op;
    rs1_zimm   <= n_zimm;
    rs1_data   <= n_data;
    irq_in     <= n_irq;
    irq_ready  <= n_ready;
    @(negedge clk);
    // rdata is the value before any write at the coming edge
    check_word("csr_rdata", model_read(csr_addr), csr_rdata);
    check_bit("irq_valid", m_valid, irq_valid);
    if (m_valid) begin
      check_id("irq_id", m_id, irq_id);
      check_level("irq_level", m_lvl, irq_level);
    end
    // valid/ready rules checked apart from the model
    if (prev_valid && !prev_ready) begin
      if (!irq_valid) begin
        errors++;
        $display("irq_valid dropped before its offer was accepted at cycle %0d", cycle_count);
      end
      check_id("irq_id held", prev_id, irq_id);
      check_level("irq_level held", prev_lvl, irq_level);
    end
    if (prev_valid && prev_ready && irq_valid) begin
      errors++;
      $display("irq_valid stayed high in the cycle after a transfer at cycle %0d", cycle_count);
    end
    prev_valid = irq_valid;
    prev_ready = irq_ready;
    prev_id    = irq_id;
    prev_lvl   = irq_level;
  endtask

  // plain reads of every named csr, one unmapped address and every config csr
  task automatic read_sweep();
    for (int s = 0; s < SweepLen; s++) begin
      n_en    = 1'b0;
      n_addr  = addr_of(s);
      n_irq   = '0;
      n_ready = 1'b0;
      cycle();
    end
  endtask

  // mode 2 csr ops, 3 pending edges vs clears, 4 arbitration, 5 handshake
  task automatic random_phase(input int mode, input int len);
    int          sel;
    logic [31:0] lvl_r;
    logic [31:0] flags_r;
    for (int i = 0; i < len; i++) begin
      sel     = rand_bits(4) % 12;
      n_addr  = addr_of(sel);
      n_op    = random_op();
      n_zimm  = r'(rand_bits(5));
      n_data  = rand_bits(32);
      n_en    = (rand_bits(2) != 0);
      n_ready = 1'(rand_bits(1));
      n_irq   = '0;
      if (mode == 3) begin
        n_irq   = VecSize'(rand_bits(VecSize) & rand_bits(VecSize));
        n_ready = 1'b0;
        // clear the pending bit while a hw edge may race it
        if (sel >= 4) begin
          n_op   = rand_bits(1) ? CSRRC : CSRRCI;
          n_data = 32'd1;
          n_zimm = 5'd1;
        end
      end else if (mode >= 4) begin
        n_irq = (mode == 5) ? VecSize'(rand_bits(VecSize)) :
                              VecSize'(rand_bits(VecSize) & rand_bits(VecSize));
        n_op  = CSRRW;
        lvl_r   = rand_bits(8);
        flags_r = rand_bits(2);
        if (sel == 1) n_data = rand_bits(7);
        if (sel >= 4) n_data = {16'h0, lvl_r[7:0], 6'h0, flags_r[1:0]};
        // mostly reads while the handshake runs
        if (mode == 5) n_en = (rand_bits(3) == 0);
      end
      cycle();
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-12s %s, %0d mismatches", name,
             (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
    errs_before = errors;
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CycleLimit) begin
      $display("timeout, the run did not finish within %0d cycles", CycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    csr_enable  = 1'b0;
    csr_addr    = '0;
    op          = CSRRW;
    rs1_zimm    = '0;
    rs1_data    = '0;
    irq_in      = '0;
    irq_ready   = 1'b0;
    n_en        = 1'b0;
    n_addr      = '0;
    n_op        = CSRRW;
    n_zimm      = '0;
    n_data      = '0;
    n_irq       = '0;
    n_ready     = 1'b0;
    prev_valid  = 1'b0;
    prev_ready  = 1'b0;
    prev_id     = '0;
    prev_lvl    = '0;
    lfsr        = 32'h87231ec8;
    checks      = 0;
    errors      = 0;
    cycle_count = 0;
    errs_before = 0;
    model_reset();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    read_sweep();
    report_test("reset");
    random_phase(2, CsrLen);
    read_sweep();
    report_test("csr_ops");
    random_phase(3, PendLen);
    read_sweep();
    report_test("pending");
    random_phase(4, ArbLen);
    report_test("arbitration");
    random_phase(5, HsLen);
    report_test("handshake");

    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/clic_pkg.sv
common/csr_bus_if.sv
logic/csr_reg.sv
clic/clic_csr_file.sv
clic/clic_arbiter.sv
clic/clic_top.sv
sim/tb_clic.sv
